/* design/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	// Number of hardware strands that share the fetch front end
	localparam int strands_per_core = 4;
	localparam int strand_idx_bits = $clog2(strands_per_core);

	// A strand number, and a mask with one bit per strand
	typedef logic [strand_idx_bits-1:0] strand_idx_t;
	typedef logic [strands_per_core-1:0] strand_mask_t;

	// Byte addresses of instructions
	typedef logic [31:0] addr_t;

	// Instruction word in big-endian bit order, after the byte swap
	typedef logic [31:0] instr_t;

	// Each strand has a small queue between fetch and strand select
	localparam int ififo_depth = 4;
	localparam int ififo_ptr_bits = $clog2(ififo_depth);
	typedef logic [ififo_ptr_bits-1:0] ififo_ptr_t;

	// The count needs one more bit than a pointer to tell full from empty
	typedef logic [ififo_ptr_bits:0] ififo_count_t;

	// Queue entry layout, from the top bit down:
	// the address after the instruction (fetch address plus 4),
	// the instruction word, the predicted-taken flag and the long latency flag
	typedef logic [65:0] ififo_entry_t;

	// Integer multiply opcode, issued to the long arithmetic pipeline
	localparam logic [5:0] op_imul = 6'd7;

	// The select stage output register is either empty or holding an entry
	typedef enum logic
	{
		idle,
		holding
	} fetch_state_t;

endpackage

`default_nettype wire

/* design/ififo_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ififo_if;
	import fetch_pkg::*;

	// Write strobe for a word returned by the cache
	logic enqueue;

	// Entry written on enqueue
	ififo_entry_t entry;

	// Empties the queue when the strand is rolled back
	logic flush;

	// Room flags used by fetch to decide if a strand may request
	logic full;
	logic almost_full;

	// Fetch stage side
	modport producer
	(
		output enqueue,
		output entry,
		output flush,
		input full,
		input almost_full
	);

	// Queue side
	modport buffer
	(
		input enqueue,
		input entry,
		input flush,
		output full,
		output almost_full
	);

endinterface

`default_nettype wire

/* design/lru_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module lru_arbiter
(
	input wire logic clk,
	input wire logic reset,
	input wire fetch_pkg::strand_mask_t request_i,
	output fetch_pkg::strand_mask_t grant_oh_o
);
	import fetch_pkg::*;

	// Row i holds a one in column j when strand i was granted less recently than strand j
	// The diagonal is kept at one so a strand never blocks itself
	strand_mask_t older_than_q [strands_per_core];

	// A requester wins when it is older than every other requester
	always_comb
	begin
		for (int i = 0; i < strands_per_core; i++)
			grant_oh_o[i] = request_i[i] && ((request_i & ~older_than_q[i]) == '0);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// Lower strand numbers start out as the oldest
			for (int i = 0; i < strands_per_core; i++)
				for (int j = 0; j < strands_per_core; j++)
					older_than_q[i][j] <= (i <= j);
		end
		else if (grant_oh_o != '0)
		begin
			for (int i = 0; i < strands_per_core; i++)
			begin
				for (int j = 0; j < strands_per_core; j++)
				begin
					// The granted strand becomes the youngest
					if (grant_oh_o[i])
						older_than_q[i][j] <= (i == j);
					else if (grant_oh_o[j])
						older_than_q[i][j] <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/instruction_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_fifo
(
	input wire logic clk,
	input wire logic reset,
	ififo_if.buffer enq,
	output logic empty_o,
	input wire logic dequeue_i,
	output fetch_pkg::ififo_entry_t head_o
);
	import fetch_pkg::*;

	ififo_entry_t storage [ififo_depth];
	ififo_ptr_t wr_ptr_q;
	ififo_ptr_t rd_ptr_q;
	ififo_count_t count_q;
	logic do_enqueue;
	logic do_dequeue;

	assign empty_o = count_q == '0;
	assign enq.full = count_q == ififo_count_t'(ififo_depth);

	// Raised when exactly one entry is still free
	assign enq.almost_full = count_q == ififo_count_t'(ififo_depth - 1);

	// Fetch never writes a full queue and select never reads an empty one,
	// but the guards keep the pointers sane if either side misbehaves
	assign do_enqueue = enq.enqueue && !enq.full;
	assign do_dequeue = dequeue_i && !empty_o;

	// Head of the queue is visible without a read strobe
	assign head_o = storage[rd_ptr_q];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else if (enq.flush)
		begin
			// Rollback wins over any read or write in the same cycle
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (do_enqueue)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_dequeue)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			// Depth is a power of two, so the pointers wrap on their own
			if (do_enqueue && !do_dequeue)
				count_q <= count_q + 1'b1;
			else if (do_dequeue && !do_enqueue)
				count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_enqueue && !enq.flush)
			storage[wr_ptr_q] <= enq.entry;
	end

endmodule

`default_nettype wire

/* design/ifetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ifetch_stage
(
	input wire logic clk,
	input wire logic reset,

	// Instruction cache request and answer
	output logic icache_request_o,
	output fetch_pkg::addr_t icache_addr_o,
	output fetch_pkg::strand_idx_t icache_strand_o,
	input wire logic [31:0] icache_data_i,
	input wire logic icache_hit_i,
	input wire logic icache_collision_i,
	input wire fetch_pkg::strand_mask_t icache_load_complete_i,

	// Rollback controller
	input wire fetch_pkg::strand_mask_t rollback_strand_i,
	input wire fetch_pkg::addr_t rollback_pc_i [fetch_pkg::strands_per_core],

	// Write side of each strand's queue
	ififo_if.producer ififo [fetch_pkg::strands_per_core]
);
	import fetch_pkg::*;

	// With a hit this cycle, pc_q of the answered strand is the address just fetched
	// Otherwise pc_q already holds the next address to fetch
	addr_t pc_q [strands_per_core];
	addr_t pc_next [strands_per_core];

	// The cache answers one cycle after the request, so the requester is remembered
	strand_mask_t last_req_oh_q;
	strand_mask_t waiting_q;
	strand_mask_t waiting_next;
	strand_mask_t grant_oh;
	strand_mask_t eligible;
	strand_mask_t hit_mask;
	strand_mask_t enqueue_mask;
	strand_mask_t full_mask;
	strand_mask_t almost_full_mask;
	logic run_q;
	logic miss;

	// Decode of the returned word
	instr_t word;
	logic [2:0] branch_type;
	logic is_branch;
	logic predicted;
	logic long_latency;
	addr_t branch_offset;

	// Cache data arrives little-endian
	assign word = {icache_data_i[7:0], icache_data_i[15:8], icache_data_i[23:16],
		icache_data_i[31:24]};

	assign is_branch = word[31:28] == 4'b1111;
	assign branch_type = word[27:25];
	assign branch_offset = {{12{word[24]}}, word[24:5]};

	// Always and call are taken, conditionals are taken only when backward
	always_comb
	begin
		predicted = 1'b0;
		if (is_branch)
		begin
			case (branch_type)
				3'd3, 3'd4: predicted = 1'b1;
				3'd0, 3'd1, 3'd2, 3'd5: predicted = word[24];
				default: predicted = 1'b0;
			endcase
		end
	end

	// Multiplies and the upper half of format A go to the long pipeline
	always_comb
	begin
		if (word[31:29] == 3'b110)
			long_latency = word[25] || word[25:20] == op_imul;
		else if (!word[31])
			long_latency = word[27:23] == op_imul[4:0];
		else
			long_latency = 1'b0;
	end

	// A hit for a strand that is rolled back this cycle is dropped
	assign hit_mask = {strands_per_core{icache_hit_i}} & last_req_oh_q;
	assign enqueue_mask = hit_mask & ~rollback_strand_i;

	// A plain miss parks the strand until the line fill is reported
	assign miss = last_req_oh_q != '0 && !icache_hit_i && !icache_collision_i;
	assign waiting_next = (waiting_q & ~icache_load_complete_i)
		| (miss ? last_req_oh_q : '0);

	// Resolve each strand's next address in the same cycle the word returns
	always_comb
	begin
		for (int s = 0; s < strands_per_core; s++)
		begin
			if (rollback_strand_i[s])
				pc_next[s] = rollback_pc_i[s];
			else if (!hit_mask[s])
				pc_next[s] = pc_q[s];
			else if (predicted)
				pc_next[s] = pc_q[s] + addr_t'(4) + branch_offset;
			else
				pc_next[s] = pc_q[s] + addr_t'(4);
		end
	end

	for (genvar s = 0; s < strands_per_core; s++)
	begin : g_strand
		assign full_mask[s] = ififo[s].full;
		assign almost_full_mask[s] = ififo[s].almost_full;
		assign ififo[s].enqueue = enqueue_mask[s];
		assign ififo[s].flush = rollback_strand_i[s];
		assign ififo[s].entry = {pc_q[s] + addr_t'(4), word, predicted, long_latency};
	end

	// A strand may ask only if its queue can take the word without dropping it
	assign eligible = ~full_mask & ~(almost_full_mask & hit_mask) & ~waiting_next
		& {strands_per_core{run_q}};

	lru_arbiter request_arb
	(
		.clk(clk),
		.reset(reset),
		.request_i(eligible),
		.grant_oh_o(grant_oh)
	);

	assign icache_request_o = grant_oh != '0;

	// One-hot to index
	always_comb
	begin
		icache_strand_o = '0;
		for (int s = 0; s < strands_per_core; s++)
			if (grant_oh[s])
				icache_strand_o = strand_idx_t'(s);
	end

	assign icache_addr_o = pc_next[icache_strand_o];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < strands_per_core; s++)
				pc_q[s] <= '0;
			last_req_oh_q <= '0;
			waiting_q <= '0;
			run_q <= 1'b0;
		end
		else
		begin
			for (int s = 0; s < strands_per_core; s++)
				pc_q[s] <= pc_next[s];
			last_req_oh_q <= grant_oh;
			waiting_q <= waiting_next;
			// Requests start on the first clock after reset is released
			run_q <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/strand_select.sv */
`timescale 1ns/1ps
`default_nettype none

module strand_select
(
	input wire logic clk,
	input wire logic reset,
	input wire fetch_pkg::strand_mask_t empty_i,
	input wire fetch_pkg::ififo_entry_t head_i [fetch_pkg::strands_per_core],
	output fetch_pkg::strand_mask_t dequeue_o,
	input wire logic issue_ready_i,
	output logic issue_valid_o,
	output fetch_pkg::strand_idx_t issue_strand_o,
	output fetch_pkg::instr_t issue_instr_o,
	output fetch_pkg::addr_t issue_pc_o,
	output logic issue_branch_predicted_o,
	output logic issue_long_latency_o,
	input wire fetch_pkg::strand_mask_t rollback_strand_i
);
	import fetch_pkg::*;

	fetch_state_t state_q;
	strand_idx_t last_strand_q;
	strand_idx_t cand;
	strand_idx_t pick;
	strand_mask_t avail;
	logic found;
	logic can_load;

	// Fields of the picked head entry
	addr_t head_next_pc;
	instr_t head_instr;
	logic head_predicted;
	logic head_long_latency;

	// A strand being flushed this cycle has nothing valid to give
	assign avail = ~empty_i & ~rollback_strand_i;

	// Search from the strand after the last one issued, wrapping around
	always_comb
	begin
		found = 1'b0;
		pick = last_strand_q;
		cand = last_strand_q;
		for (int k = 1; k <= strands_per_core; k++)
		begin
			cand = last_strand_q + strand_idx_t'(k);
			if (!found && avail[cand])
			begin
				found = 1'b1;
				pick = cand;
			end
		end
	end

	assign {head_next_pc, head_instr, head_predicted, head_long_latency} = head_i[pick];

	// The register may be refilled when empty, when consumed, or when its strand rolls back
	assign can_load = state_q == idle || issue_ready_i || rollback_strand_i[issue_strand_o];

	always_comb
	begin
		dequeue_o = '0;
		if (can_load && found)
			dequeue_o[pick] = 1'b1;
	end

	assign issue_valid_o = state_q == holding;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_q <= idle;
			// Start so that strand 0 is searched first
			last_strand_q <= '1;
		end
		else if (can_load)
		begin
			if (found)
			begin
				state_q <= holding;
				last_strand_q <= pick;
			end
			else
				state_q <= idle;
		end
	end

	// Issue payload, loaded together with the state change
	always_ff @(posedge clk)
	begin
		if (can_load && found)
		begin
			issue_strand_o <= pick;
			issue_instr_o <= head_instr;
			// The entry stores the following address, so step back one word
			issue_pc_o <= head_next_pc - addr_t'(4);
			issue_branch_predicted_o <= head_predicted;
			issue_long_latency_o <= head_long_latency;
		end
	end

endmodule

`default_nettype wire

/* design/fetch_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_top
(
	input wire logic clk,
	input wire logic reset,

	// Instruction cache
	output logic icache_request_o,
	output fetch_pkg::addr_t icache_addr_o,
	output fetch_pkg::strand_idx_t icache_strand_o,
	input wire logic [31:0] icache_data_i,
	input wire logic icache_hit_i,
	input wire logic icache_collision_i,
	input wire fetch_pkg::strand_mask_t icache_load_complete_i,

	// Rollback controller, one 32-bit address per strand with strand 0 in the low bits
	input wire fetch_pkg::strand_mask_t rollback_strand_i,
	input wire logic [fetch_pkg::strands_per_core*32-1:0] rollback_pc_i,

	// Issue port
	input wire logic issue_ready_i,
	output logic issue_valid_o,
	output fetch_pkg::strand_idx_t issue_strand_o,
	output fetch_pkg::instr_t issue_instr_o,
	output fetch_pkg::addr_t issue_pc_o,
	output logic issue_branch_predicted_o,
	output logic issue_long_latency_o
);
	import fetch_pkg::*;

	addr_t rollback_pc [strands_per_core];
	ififo_entry_t head [strands_per_core];
	strand_mask_t empty;
	strand_mask_t dequeue;

	ififo_if ififo [strands_per_core] ();

	ifetch_stage fetch
	(
		.clk(clk),
		.reset(reset),
		.icache_request_o(icache_request_o),
		.icache_addr_o(icache_addr_o),
		.icache_strand_o(icache_strand_o),
		.icache_data_i(icache_data_i),
		.icache_hit_i(icache_hit_i),
		.icache_collision_i(icache_collision_i),
		.icache_load_complete_i(icache_load_complete_i),
		.rollback_strand_i(rollback_strand_i),
		.rollback_pc_i(rollback_pc),
		.ififo(ififo)
	);

	for (genvar s = 0; s < strands_per_core; s++)
	begin : g_queue
		assign rollback_pc[s] = rollback_pc_i[s*32 +: 32];

		instruction_fifo queue
		(
			.clk(clk),
			.reset(reset),
			.enq(ififo[s]),
			.empty_o(empty[s]),
			.dequeue_i(dequeue[s]),
			.head_o(head[s])
		);
	end

	strand_select select
	(
		.clk(clk),
		.reset(reset),
		.empty_i(empty),
		.head_i(head),
		.dequeue_o(dequeue),
		.issue_ready_i(issue_ready_i),
		.issue_valid_o(issue_valid_o),
		.issue_strand_o(issue_strand_o),
		.issue_instr_o(issue_instr_o),
		.issue_pc_o(issue_pc_o),
		.issue_branch_predicted_o(issue_branch_predicted_o),
		.issue_long_latency_o(issue_long_latency_o),
		.rollback_strand_i(rollback_strand_i)
	);

endmodule

`default_nettype wire

/* tests/fetch_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_chk
(
	input wire logic clk,
	input wire logic reset,
	input wire logic icache_request_i,
	input wire fetch_pkg::strand_idx_t icache_strand_i,
	input wire logic icache_hit_i,
	input wire logic icache_collision_i,
	input wire fetch_pkg::strand_mask_t icache_load_complete_i,
	input wire fetch_pkg::strand_mask_t rollback_strand_i,
	input wire fetch_pkg::strand_mask_t queue_empty_i,
	input wire logic issue_ready_i,
	input wire logic issue_valid_i,
	input wire fetch_pkg::strand_idx_t issue_strand_i,
	input wire fetch_pkg::instr_t issue_instr_i,
	input wire fetch_pkg::addr_t issue_pc_i,
	input wire logic issue_branch_predicted_i,
	input wire logic issue_long_latency_i
);
	import fetch_pkg::*;

	int failures = 0;
	strand_mask_t last_req_q;
	strand_mask_t waiting_q;
	strand_mask_t waiting_next;

	// Waiting strands worked out from the cache answers alone
	always_comb
	begin
		waiting_next = waiting_q & ~icache_load_complete_i;
		if (last_req_q != '0 && !icache_hit_i && !icache_collision_i)
			waiting_next = waiting_next | last_req_q;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			last_req_q <= '0;
			waiting_q <= '0;
		end
		else
		begin
			last_req_q <= icache_request_i ? strand_mask_t'(1) << icache_strand_i : '0;
			waiting_q <= waiting_next;
		end
	end

	request_in_reset: assert property (@(posedge clk) reset |-> !icache_request_i)
	else
	begin
		failures++;
		$error("cache request raised during reset");
	end

	// A stalled issue register holds unless its own strand is rolled back
	stall_hold: assert property (@(posedge clk) disable iff (reset)
		issue_valid_i && !issue_ready_i && !rollback_strand_i[issue_strand_i]
		|=> issue_valid_i && $stable(issue_strand_i) && $stable(issue_instr_i)
		&& $stable(issue_pc_i) && $stable(issue_branch_predicted_i)
		&& $stable(issue_long_latency_i))
	else
	begin
		failures++;
		$error("issue outputs changed under stall");
	end

	no_request_while_waiting: assert property (@(posedge clk) disable iff (reset)
		icache_request_i |-> !waiting_next[icache_strand_i])
	else
	begin
		failures++;
		$error("request from strand %0d still waiting on a line fill", icache_strand_i);
	end

	valid_from_queue: assert property (@(posedge clk) disable iff (reset)
		$rose(issue_valid_i) |-> !(&$past(queue_empty_i)))
	else
	begin
		failures++;
		$error("issue valid rose with every queue empty");
	end

endmodule

bind fetch_unit_top fetch_chk chk
(
	.clk(clk),
	.reset(reset),
	.icache_request_i(icache_request_o),
	.icache_strand_i(icache_strand_o),
	.icache_hit_i(icache_hit_i),
	.icache_collision_i(icache_collision_i),
	.icache_load_complete_i(icache_load_complete_i),
	.rollback_strand_i(rollback_strand_i),
	.queue_empty_i(empty),
	.issue_ready_i(issue_ready_i),
	.issue_valid_i(issue_valid_o),
	.issue_strand_i(issue_strand_o),
	.issue_instr_i(issue_instr_o),
	.issue_pc_i(issue_pc_o),
	.issue_branch_predicted_i(issue_branch_predicted_o),
	.issue_long_latency_i(issue_long_latency_o)
);

`default_nettype wire

/* tests/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
	import fetch_pkg::*;

	localparam int clk_period = 40;
	localparam int num_tests = 4;
	localparam int issues_per_test = 150;

	// Roughly three cycles per issue once stalls, misses and rollbacks are mixed in
	localparam int stim_cycles = num_tests * issues_per_test * 3;
	localparam int timeout_cycles = 8 * stim_cycles;

	logic clk;
	logic reset;
	logic icache_request;
	addr_t icache_addr;
	strand_idx_t icache_strand;
	logic [31:0] icache_data;
	logic icache_hit;
	logic icache_collision;
	strand_mask_t icache_load_complete;
	strand_mask_t rollback_strand;
	logic [strands_per_core*32-1:0] rollback_pc;
	logic issue_ready;
	logic issue_valid;
	strand_idx_t issue_strand;
	instr_t issue_instr;
	addr_t issue_pc;
	logic issue_predicted;
	logic issue_long_latency;

	// 4 KB of instruction words, stored in issue order (already byte swapped)
	instr_t mem [1024];

	// Reference stream, the next address each strand must issue
	addr_t exp_pc [strands_per_core];
	int issued [strands_per_core];
	int lc_timer [strands_per_core];

	// Request seen at the falling edge, answered at the next rising edge
	logic req_seen;
	addr_t req_addr;
	strand_idx_t req_strand;

	// Issue register contents while a stall is pending
	logic stall_seen;
	strand_idx_t held_strand;
	addr_t held_pc;
	instr_t held_instr;
	logic held_predicted;
	logic held_long_latency;

	int hit_pct;
	int ready_pct;
	int rollback_pct;
	int test_issues;
	int tests = 0;
	int checks = 0;
	int errors = 0;
	int cycle_count = 0;
	string cur_test = "reset";

	fetch_unit_top uut
	(
		.clk(clk),
		.reset(reset),
		.icache_request_o(icache_request),
		.icache_addr_o(icache_addr),
		.icache_strand_o(icache_strand),
		.icache_data_i(icache_data),
		.icache_hit_i(icache_hit),
		.icache_collision_i(icache_collision),
		.icache_load_complete_i(icache_load_complete),
		.rollback_strand_i(rollback_strand),
		.rollback_pc_i(rollback_pc),
		.issue_ready_i(issue_ready),
		.issue_valid_o(issue_valid),
		.issue_strand_o(issue_strand),
		.issue_instr_o(issue_instr),
		.issue_pc_o(issue_pc),
		.issue_branch_predicted_o(issue_predicted),
		.issue_long_latency_o(issue_long_latency)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	// The cache returns words little-endian
	function automatic logic [31:0] swap_bytes(input instr_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Always and call are taken, conditionals only when the offset is negative
	function automatic bit predict_taken(input instr_t w);
		if (w[31:28] != 4'b1111)
			return 1'b0;
		case (w[27:25])
			3'd3, 3'd4: return 1'b1;
			3'd0, 3'd1, 3'd2, 3'd5: return w[24];
			default: return 1'b0;
		endcase
	endfunction

	function automatic bit is_long_latency(input instr_t w);
		if (w[31:29] == 3'b110)
			return w[25] || w[25:20] == 6'd7;
		if (!w[31])
			return w[27:23] == 5'd7;
		return 1'b0;
	endfunction

	function automatic addr_t next_addr(input addr_t pc, input instr_t w);
		addr_t offset;
		offset = {{12{w[24]}}, w[24:5]};
		return predict_taken(w) ? pc + 32'd4 + offset : pc + 32'd4;
	endfunction

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("[ERROR] %s %s: expected %h, actual %h", cur_test, name, exp, act);
		end
	endtask

	task automatic check_instr(input string name, input instr_t exp, input instr_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("[ERROR] %s %s: expected %h, actual %h", cur_test, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input bit exp, input bit act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("[ERROR] %s %s: expected %0b, actual %0b", cur_test, name, exp, act);
		end
	endtask

	task automatic check_strand(input string name, input strand_idx_t exp,
		input strand_idx_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("[ERROR] %s %s: expected %0d, actual %0d", cur_test, name, exp, act);
		end
	endtask

	// Mix of branches of every type, both IMUL forms and plain words
	task automatic fill_memory();
		int kind;
		int ow;
		instr_t w;
		for (int i = 0; i < 1024; i++)
		begin
			kind = $urandom_range(9, 0);
			ow = $urandom_range(63, 0) - 32;
			w = $urandom;
			if (kind < 3)
				w = {4'b1111, 3'($urandom), 20'(ow * 4), 5'($urandom)};
			else if (kind == 3)
				w = {3'b110, 3'($urandom), 6'd7, 20'($urandom)};
			else if (kind == 4)
				w = {1'b0, 3'($urandom), 5'd7, 23'($urandom)};
			else if (w[31:28] == 4'b1111)
				w[28] = 1'b0;
			mem[i] = w;
		end
	endtask

	// Cache answers, line fills, back-pressure and rollbacks for the coming cycle
	task automatic drive_inputs();
		int roll;
		strand_idx_t rs;
		strand_mask_t done;
		done = '0;
		for (int s = 0; s < strands_per_core; s++)
		begin
			if (lc_timer[s] > 0)
			begin
				lc_timer[s]--;
				if (lc_timer[s] == 0)
					done[s] = 1'b1;
			end
		end
		icache_load_complete <= done;
		icache_hit <= 1'b0;
		icache_collision <= 1'b0;
		icache_data <= $urandom;
		if (req_seen)
		begin
			roll = $urandom_range(99, 0);
			icache_data <= swap_bytes(mem[req_addr[11:2]]);
			if (roll < hit_pct)
				icache_hit <= 1'b1;
			else if (roll < hit_pct + 6)
				icache_collision <= 1'b1;
			else
				lc_timer[req_strand] = $urandom_range(6, 2);
		end
		issue_ready <= $urandom_range(99, 0) < ready_pct;
		rollback_strand <= '0;
		if ($urandom_range(99, 0) < rollback_pct)
		begin
			rs = strand_idx_t'($urandom_range(strands_per_core - 1, 0));
			rollback_strand <= strand_mask_t'(1) << rs;
			rollback_pc[rs*32 +: 32] <= {20'd0, 10'($urandom), 2'b00};
		end
	endtask

	// Called where outputs are settled; a handshake here completes at the next rising edge
	task automatic monitor_issue();
		int s;
		instr_t w;
		if (stall_seen)
		begin
			check_flag("stall_valid", 1'b1, issue_valid);
			check_strand("stall_strand", held_strand, issue_strand);
			check_addr("stall_pc", held_pc, issue_pc);
			check_instr("stall_instr", held_instr, issue_instr);
			check_flag("stall_predicted", held_predicted, issue_predicted);
			check_flag("stall_long_latency", held_long_latency, issue_long_latency);
		end
		if (issue_valid && issue_ready)
		begin
			s = issue_strand;
			w = mem[exp_pc[s][11:2]];
			check_addr("issue_pc", exp_pc[s], issue_pc);
			check_instr("issue_instr", w, issue_instr);
			check_flag("predicted", predict_taken(w), issue_predicted);
			check_flag("long_latency", is_long_latency(w), issue_long_latency);
			// Step the reference stream past the issued word
			exp_pc[s] = next_addr(exp_pc[s], w);
			issued[s]++;
			test_issues++;
		end
		stall_seen = issue_valid && !issue_ready && !rollback_strand[issue_strand];
		held_strand = issue_strand;
		held_pc = issue_pc;
		held_instr = issue_instr;
		held_predicted = issue_predicted;
		held_long_latency = issue_long_latency;
		// A rollback lands at the same edge, after any handshake in this cycle
		for (int k = 0; k < strands_per_core; k++)
			if (rollback_strand[k])
				exp_pc[k] = rollback_pc[k*32 +: 32];
	endtask

	always @(negedge clk)
	begin
		req_seen = 1'b0;
		if (!reset)
		begin
			req_seen = icache_request;
			req_addr = icache_addr;
			req_strand = icache_strand;
			monitor_issue();
		end
	end

	task automatic run_test(input string name, input int hit, input int ready, input int rb);
		int start_checks;
		int start_errors;
		cur_test = name;
		hit_pct = hit;
		ready_pct = ready;
		rollback_pct = rb;
		start_checks = checks;
		start_errors = errors;
		test_issues = 0;
		while (test_issues < issues_per_test)
		begin
			@(posedge clk);
			drive_inputs();
		end
		tests++;
		$display("%s: %0d issued, %0d checks, %0d errors", name, test_issues,
			checks - start_checks, errors - start_errors);
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("Timeout: %0d issues not reached within %0d cycles", issues_per_test,
				timeout_cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(32'h710f));
		reset <= 1'b1;
		icache_data = '0;
		icache_hit = 1'b0;
		icache_collision = 1'b0;
		icache_load_complete = '0;
		rollback_strand = '0;
		rollback_pc = '0;
		issue_ready = 1'b0;
		stall_seen = 1'b0;
		req_seen = 1'b0;
		for (int s = 0; s < strands_per_core; s++)
		begin
			exp_pc[s] = '0;
			issued[s] = 0;
			lc_timer[s] = 0;
		end
		fill_memory();
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		run_test("sequential_fetch", 100, 100, 0);
		run_test("misses_collisions", 70, 100, 0);
		run_test("back_pressure", 70, 40, 0);
		run_test("rollback", 70, 70, 3);

		for (int s = 0; s < strands_per_core; s++)
		begin
			if (issued[s] == 0)
			begin
				errors++;
				$display("Strand %0d never issued an instruction", s);
			end
		end
		if (uut.chk.failures != 0)
		begin
			errors += uut.chk.failures;
			$display("%0d assertion failures in the bound checker", uut.chk.failures);
		end
		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
design/fetch_pkg.sv
design/ififo_if.sv
design/lru_arbiter.sv
design/instruction_fifo.sv
design/ifetch_stage.sv
design/strand_select.sv
design/fetch_unit_top.sv
tests/fetch_chk.sv
tests/fetch_tb.sv
